// ==== chn_ahb_slave.sv ====
`timescale 1ns/100ps

module chn_ahb_slave (
  input  logic                           hclk,
  input  logic                           hrst_n,
  input  logic                           hsel,
  input  logic [1:0]                     htrans,
  input  logic [chn_reg_pkg::addr_w-1:0] haddr,
  input  logic                           hwrite,
  input  logic [chn_reg_pkg::data_w-1:0] cfg_rdata,
  input  logic [chn_reg_pkg::data_w-1:0] int_rdata,
  output chn_reg_pkg::reg_sel_t          wr_sel,
  output chn_reg_pkg::reg_sel_t          rd_sel,
  output logic [chn_reg_pkg::data_w-1:0] hrdata
);

  import chn_reg_pkg::*;

  logic     access;
  reg_sel_t addr_hit;

  // IDLE and BUSY never start an access.
  assign access = hsel && ((htrans == htrans_nonseq) || (htrans == htrans_seq));

  always_comb begin
    addr_hit = '0;
    case (haddr)
      chn_base_addr + sar_ofs: begin
        addr_hit[sel_sar] = 1'b1;
      end
      chn_base_addr + dar_ofs: begin
        addr_hit[sel_dar] = 1'b1;
      end
      chn_base_addr + ctrl_a_ofs: begin
        addr_hit[sel_ctrl_a] = 1'b1;
      end
      chn_base_addr + ctrl_b_ofs: begin
        addr_hit[sel_ctrl_b] = 1'b1;
      end
      chn_base_addr + int_mask_ofs: begin
        addr_hit[sel_int_mask] = 1'b1;
      end
      chn_base_addr + int_status_ofs: begin
        addr_hit[sel_int_status] = 1'b1;
      end
      chn_base_addr + int_clear_ofs: begin
        addr_hit[sel_int_clear] = 1'b1;
      end
      chn_base_addr + soft_req_ofs: begin
        addr_hit[sel_soft_req] = 1'b1;
      end
      chn_base_addr + chn_en_ofs: begin
        addr_hit[sel_chn_en] = 1'b1;
      end
      chn_base_addr + grplen_ext_ofs: begin
        addr_hit[sel_grplen_ext] = 1'b1;
      end
      default: begin
        addr_hit = '0;  // Unmapped.
      end
    endcase
  end

  // Selects live for the data phase only.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      wr_sel <= '0;
      rd_sel <= '0;
    end else begin
      wr_sel <= (access && hwrite) ? addr_hit : '0;
      rd_sel <= (access && !hwrite) ? addr_hit : '0;
    end
  end

  // Each block returns zero unless selected.
  assign hrdata = cfg_rdata | int_rdata;

endmodule

// ==== chn_cfg_regs.sv ====
`timescale 1ns/100ps

module chn_cfg_regs (
  input  logic                                hclk,
  input  logic                                hrst_n,
  input  chn_reg_pkg::reg_sel_t               wr_sel,
  input  chn_reg_pkg::reg_sel_t               rd_sel,
  input  logic [chn_reg_pkg::data_w-1:0]      hwdata,
  input  logic                                en_clr,
  output logic [chn_reg_pkg::data_w-1:0]      sar,
  output logic [chn_reg_pkg::data_w-1:0]      dar,
  output logic                                dgrpaddrc,
  output logic                                sgrpaddrc,
  output logic                                grpmc,
  output logic [2:0]                          chintmdc,
  output logic [chn_reg_pkg::block_tl_w-1:0]  block_tl,
  output logic [chn_reg_pkg::group_len_w-1:0] group_len,
  output logic [1:0]                          sinc,
  output logic [1:0]                          dinc,
  output logic [1:0]                          src_tr_width,
  output logic [1:0]                          dst_tr_width,
  output logic [chn_reg_pkg::prot_w-1:0]      protctl,
  output logic                                endlan,
  output logic                                srcdtlgc,
  output logic [1:0]                          trgtmdc,
  output logic                                int_en,
  output logic                                chn_en,
  output logic                                soft_trig,
  output logic [chn_reg_pkg::data_w-1:0]      cfg_rdata
);

  import chn_reg_pkg::*;

  logic              cfg_open;
  logic [3:0]        grp_lo;
  logic [1:0]        grp_hi;
  logic [data_w-1:0] ctrl_a_word;
  logic [data_w-1:0] ctrl_b_word;

  assign cfg_open  = !chn_en;  // Config frozen while channel runs.
  assign group_len = {grp_hi, grp_lo};

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      sar          <= '0;
      dar          <= '0;
      dgrpaddrc    <= 1'b0;
      sgrpaddrc    <= 1'b0;
      grpmc        <= 1'b0;
      chintmdc     <= '0;
      block_tl     <= '0;
      grp_lo       <= '0;
      sinc         <= '0;
      dinc         <= '0;
      src_tr_width <= '0;
      dst_tr_width <= '0;
      grp_hi       <= '0;
      protctl      <= '0;
      endlan       <= 1'b0;
      srcdtlgc     <= 1'b0;
      trgtmdc      <= '0;
      int_en       <= 1'b0;
    end else if (cfg_open) begin
      if (wr_sel[sel_sar]) sar <= hwdata;
      if (wr_sel[sel_dar]) dar <= hwdata;
      if (wr_sel[sel_ctrl_a]) begin
        dgrpaddrc    <= hwdata[ca_dgrpaddrc_lsb];
        sgrpaddrc    <= hwdata[ca_sgrpaddrc_lsb];
        grpmc        <= hwdata[ca_grpmc_lsb];
        chintmdc     <= hwdata[ca_chintmdc_lsb +: 3];
        block_tl     <= hwdata[ca_block_tl_lsb +: block_tl_w];
        grp_lo       <= hwdata[ca_group_len_lsb +: 4];
        sinc         <= hwdata[ca_sinc_lsb +: 2];
        dinc         <= hwdata[ca_dinc_lsb +: 2];
        src_tr_width <= hwdata[ca_src_tr_width_lsb +: 2];
        dst_tr_width <= hwdata[ca_dst_tr_width_lsb +: 2];
      end
      if (wr_sel[sel_grplen_ext]) grp_hi <= hwdata[1:0];  // Upper group length.
      if (wr_sel[sel_ctrl_b]) begin
        protctl  <= hwdata[cb_protctl_lsb +: prot_w];
        endlan   <= hwdata[cb_endlan_lsb];
        srcdtlgc <= hwdata[cb_srcdtlgc_lsb];
        trgtmdc  <= hwdata[cb_trgtmdc_lsb +: 2];
        int_en   <= hwdata[cb_int_en_lsb];
      end
    end
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      chn_en    <= 1'b0;
      soft_trig <= 1'b0;
    end else begin
      if (wr_sel[sel_chn_en]) begin
        chn_en <= hwdata[0];  // Bus write beats FSM clear.
      end else if (en_clr) begin
        chn_en <= 1'b0;
      end
      soft_trig <= wr_sel[sel_soft_req] & hwdata[0];
    end
  end

  always_comb begin
    ctrl_a_word = '0;
    ctrl_a_word[ca_dgrpaddrc_lsb]                = dgrpaddrc;
    ctrl_a_word[ca_sgrpaddrc_lsb]                = sgrpaddrc;
    ctrl_a_word[ca_grpmc_lsb]                    = grpmc;
    ctrl_a_word[ca_chintmdc_lsb +: 3]            = chintmdc;
    ctrl_a_word[ca_block_tl_lsb +: block_tl_w]   = block_tl;
    ctrl_a_word[ca_group_len_lsb +: 4]           = grp_lo;
    ctrl_a_word[ca_sinc_lsb +: 2]                = sinc;
    ctrl_a_word[ca_dinc_lsb +: 2]                = dinc;
    ctrl_a_word[ca_src_tr_width_lsb +: 2]        = src_tr_width;
    ctrl_a_word[ca_dst_tr_width_lsb +: 2]        = dst_tr_width;
    ctrl_b_word = '0;
    ctrl_b_word[cb_protctl_lsb +: prot_w]        = protctl;
    ctrl_b_word[cb_endlan_lsb]                   = endlan;
    ctrl_b_word[cb_srcdtlgc_lsb]                 = srcdtlgc;
    ctrl_b_word[cb_trgtmdc_lsb +: 2]             = trgtmdc;
    ctrl_b_word[cb_int_en_lsb]                   = int_en;
  end

  // At most one select bit is set.
  always_comb begin
    cfg_rdata = '0;
    if (rd_sel[sel_sar]) cfg_rdata = sar;
    if (rd_sel[sel_dar]) cfg_rdata = dar;
    if (rd_sel[sel_ctrl_a]) cfg_rdata = ctrl_a_word;
    if (rd_sel[sel_ctrl_b]) cfg_rdata = ctrl_b_word;
    if (rd_sel[sel_grplen_ext]) cfg_rdata = {{(data_w-2){1'b0}}, grp_hi};
    if (rd_sel[sel_chn_en]) cfg_rdata = {{(data_w-1){1'b0}}, chn_en};
  end

endmodule

// ==== chn_int_ctrl.sv ====
`timescale 1ns/100ps

module chn_int_ctrl (
  input  logic                           hclk,
  input  logic                           hrst_n,
  input  chn_reg_pkg::reg_sel_t          wr_sel,
  input  chn_reg_pkg::reg_sel_t          rd_sel,
  input  logic [chn_reg_pkg::data_w-1:0] hwdata,
  input  logic                           int_en,
  input  logic                           err_vld,
  input  logic                           tfr_vld,
  input  logic                           htfr_vld,
  input  logic                           trgcmp_vld,
  input  logic                           pend_vld,
  output logic                           chn_irq,
  output logic                           pend_out,
  output logic [chn_reg_pkg::data_w-1:0] int_rdata
);

  import chn_reg_pkg::*;

  logic [int_src_n-1:0] int_evt;
  logic [int_src_n-1:0] int_mask;
  logic [int_src_n-1:0] int_status;
  logic [int_src_n-1:0] clr_pls;

  always_comb begin
    int_evt             = '0;
    int_evt[int_err]    = err_vld;
    int_evt[int_tfr]    = tfr_vld;
    int_evt[int_htfr]   = htfr_vld;
    int_evt[int_trgcmp] = trgcmp_vld;
    int_evt[int_pend]   = pend_vld;
  end

  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      int_mask <= '0;
      clr_pls  <= '0;
    end else begin
      if (wr_sel[sel_int_mask]) int_mask <= hwdata[int_src_n-1:0];
      clr_pls <= wr_sel[sel_int_clear] ? hwdata[int_src_n-1:0] : '0;  // One cycle.
    end
  end

  // Sticky bits where a new event beats a clear.
  always_ff @(posedge hclk or negedge hrst_n) begin
    if (!hrst_n) begin
      int_status <= '0;
    end else begin
      int_status <= (int_status & ~clr_pls) | int_evt;
    end
  end

  assign pend_out = int_status[int_pend];
  assign chn_irq  = (|(int_status & int_mask)) & int_en;

  always_comb begin
    int_rdata = '0;
    if (rd_sel[sel_int_mask]) begin
      int_rdata[int_src_n-1:0] = int_mask;
    end
    if (rd_sel[sel_int_status]) begin
      int_rdata[int_src_n-1:0] = int_status;
    end
  end

endmodule

// ==== chn_reg_pkg.sv ====
package chn_reg_pkg;

  localparam int addr_w = 10;
  localparam int data_w = 32;

  localparam logic [addr_w-1:0] chn_base_addr = 10'h2D0;

  // Register offsets from the channel base.
  localparam logic [addr_w-1:0] sar_ofs        = 10'h000;
  localparam logic [addr_w-1:0] dar_ofs        = 10'h004;
  localparam logic [addr_w-1:0] ctrl_a_ofs     = 10'h008;
  localparam logic [addr_w-1:0] ctrl_b_ofs     = 10'h00C;
  localparam logic [addr_w-1:0] int_mask_ofs   = 10'h010;
  localparam logic [addr_w-1:0] int_status_ofs = 10'h014;
  localparam logic [addr_w-1:0] int_clear_ofs  = 10'h018;
  localparam logic [addr_w-1:0] soft_req_ofs   = 10'h01C;
  localparam logic [addr_w-1:0] chn_en_ofs     = 10'h020;
  localparam logic [addr_w-1:0] grplen_ext_ofs = 10'h024;

  localparam logic [1:0] htrans_nonseq = 2'b10;
  localparam logic [1:0] htrans_seq    = 2'b11;

  localparam int reg_n = 10;

  localparam int sel_sar        = 0;
  localparam int sel_dar        = 1;
  localparam int sel_ctrl_a     = 2;
  localparam int sel_ctrl_b     = 3;
  localparam int sel_int_mask   = 4;
  localparam int sel_int_status = 5;
  localparam int sel_int_clear  = 6;
  localparam int sel_soft_req   = 7;
  localparam int sel_chn_en     = 8;
  localparam int sel_grplen_ext = 9;

  typedef logic [reg_n-1:0] reg_sel_t;  // One-hot register select.

  localparam int block_tl_w  = 12;
  localparam int group_len_w = 6;
  localparam int prot_w      = 4;
  localparam int int_src_n   = 5;

  // Same layout in mask, status and clear.
  localparam int int_err    = 0;
  localparam int int_tfr    = 1;
  localparam int int_htfr   = 2;
  localparam int int_trgcmp = 3;
  localparam int int_pend   = 4;

  localparam int ca_dgrpaddrc_lsb    = 31;
  localparam int ca_sgrpaddrc_lsb    = 29;
  localparam int ca_grpmc_lsb        = 28;
  localparam int ca_chintmdc_lsb     = 24;
  localparam int ca_block_tl_lsb     = 12;
  localparam int ca_group_len_lsb    = 8;
  localparam int ca_sinc_lsb         = 6;
  localparam int ca_dinc_lsb         = 4;
  localparam int ca_src_tr_width_lsb = 2;
  localparam int ca_dst_tr_width_lsb = 0;

  localparam int cb_protctl_lsb  = 15;
  localparam int cb_endlan_lsb   = 14;
  localparam int cb_srcdtlgc_lsb = 13;
  localparam int cb_trgtmdc_lsb  = 1;
  localparam int cb_int_en_lsb   = 0;

endpackage

// ==== chn_regs.f ====
chn_reg_pkg.sv
chn_ahb_slave.sv
chn_cfg_regs.sv
chn_int_ctrl.sv
chn_regs_top.sv
chn_regs_checker.sv
tb_chn_regs.sv

// ==== chn_regs_checker.sv ====
`timescale 1ns/100ps

module chn_regs_checker (
  input  logic                                hclk,
  input  logic                                hrst_n,
  input  logic                                exp_valid,
  input  logic                                exp_read,
  input  logic [chn_reg_pkg::addr_w-1:0]      exp_addr,
  input  logic [chn_reg_pkg::data_w-1:0]      exp_rdata,
  input  logic [3:0]                          exp_flags,
  input  logic [chn_reg_pkg::data_w-1:0]      hrdata,
  input  logic                                soft_trig,
  input  logic                                chn_irq,
  input  logic                                pend_out,
  input  logic                                chn_en,
  input  logic [chn_reg_pkg::data_w-1:0]      sar,
  input  logic [chn_reg_pkg::data_w-1:0]      dar,
  input  logic                                dgrpaddrc,
  input  logic                                sgrpaddrc,
  input  logic                                grpmc,
  input  logic [2:0]                          chintmdc,
  input  logic [chn_reg_pkg::block_tl_w-1:0]  block_tl,
  input  logic [chn_reg_pkg::group_len_w-1:0] group_len,
  input  logic [1:0]                          sinc,
  input  logic [1:0]                          dinc,
  input  logic [1:0]                          src_tr_width,
  input  logic [1:0]                          dst_tr_width,
  input  logic [chn_reg_pkg::prot_w-1:0]      protctl,
  input  logic                                endlan,
  input  logic                                srcdtlgc,
  input  logic [1:0]                          trgtmdc,
  input  logic                                int_en,
  output int                                  err_cnt,
  output int                                  chk_cnt
);

  import chn_reg_pkg::*;

  logic       flags_due;
  logic [3:0] flags_exp;

  task automatic compare(input string name, input logic [data_w-1:0] exp_val,
                         input logic [data_w-1:0] act_val);
    chk_cnt++;
    if (act_val !== exp_val) begin
      err_cnt++;
      $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp_val, act_val);
    end
  endtask

  // Config outputs carry the fields of the word read back.
  task automatic compare_cfg_outputs(input logic [addr_w-1:0] addr,
                                     input logic [data_w-1:0] word);
    case (addr)
      chn_base_addr + sar_ofs: begin
        compare("sar", word, sar);
      end
      chn_base_addr + dar_ofs: begin
        compare("dar", word, dar);
      end
      chn_base_addr + ctrl_a_ofs: begin
        compare("dgrpaddrc", data_w'(word[ca_dgrpaddrc_lsb]), data_w'(dgrpaddrc));
        compare("sgrpaddrc", data_w'(word[ca_sgrpaddrc_lsb]), data_w'(sgrpaddrc));
        compare("grpmc", data_w'(word[ca_grpmc_lsb]), data_w'(grpmc));
        compare("chintmdc", data_w'(word[ca_chintmdc_lsb +: 3]), data_w'(chintmdc));
        compare("block_tl", data_w'(word[ca_block_tl_lsb +: block_tl_w]),
                data_w'(block_tl));
        compare("group_len[3:0]", data_w'(word[ca_group_len_lsb +: 4]),
                data_w'(group_len[3:0]));
        compare("sinc", data_w'(word[ca_sinc_lsb +: 2]), data_w'(sinc));
        compare("dinc", data_w'(word[ca_dinc_lsb +: 2]), data_w'(dinc));
        compare("src_tr_width", data_w'(word[ca_src_tr_width_lsb +: 2]),
                data_w'(src_tr_width));
        compare("dst_tr_width", data_w'(word[ca_dst_tr_width_lsb +: 2]),
                data_w'(dst_tr_width));
      end
      chn_base_addr + ctrl_b_ofs: begin
        compare("protctl", data_w'(word[cb_protctl_lsb +: prot_w]), data_w'(protctl));
        compare("endlan", data_w'(word[cb_endlan_lsb]), data_w'(endlan));
        compare("srcdtlgc", data_w'(word[cb_srcdtlgc_lsb]), data_w'(srcdtlgc));
        compare("trgtmdc", data_w'(word[cb_trgtmdc_lsb +: 2]), data_w'(trgtmdc));
        compare("int_en", data_w'(word[cb_int_en_lsb]), data_w'(int_en));
      end
      chn_base_addr + grplen_ext_ofs: begin
        compare("group_len[5:4]", data_w'(word[1:0]), data_w'(group_len[5:4]));
      end
      default: begin
      end
    endcase
  endtask

  // Read data is checked at the edge that closes its data phase.
  // Side outputs lag one edge, so they show the state after the write or event.
  always @(posedge hclk) begin
    if (!hrst_n) begin
      err_cnt   = 0;
      chk_cnt   = 0;
      flags_due = 1'b0;
      flags_exp = '0;
    end else begin
      if (exp_valid && exp_read) begin
        compare("hrdata", exp_rdata, hrdata);
        compare_cfg_outputs(exp_addr, exp_rdata);
      end
      if (flags_due) begin
        compare("soft_trig", {31'b0, flags_exp[3]}, {31'b0, soft_trig});
        compare("chn_irq", {31'b0, flags_exp[2]}, {31'b0, chn_irq});
        compare("pend_out", {31'b0, flags_exp[1]}, {31'b0, pend_out});
        compare("chn_en", {31'b0, flags_exp[0]}, {31'b0, chn_en});
      end
      flags_due = exp_valid;
      flags_exp = exp_flags;
    end
  end

endmodule

// ==== chn_regs_patterns.txt ====
# columns (hex): op addr data exp_rdata exp_flags; op 0 idle, 1 write, 2 read, 3 events
# events: addr is a mask of err tfr htfr trgcmp pend en_clr (bit 0 up)
# exp_flags: soft_trig chn_irq pend_out chn_en after the line's closing edge
2 2D0 0 0 0
2 2D8 0 0 0
2 2DC 0 0 0
2 2E4 0 0 0
2 2F0 0 0 0
1 2D0 12345678 0 0
2 2D0 0 12345678 0
1 2D8 FFFFFFFF 0 0
2 2D8 0 B7FFFFFF 0
1 2DC FFFFFFFF 0 0
2 2DC 0 0007E007 0
1 2F4 FFFFFFFF 0 0
2 2F4 0 3 0
1 2F0 1 0 1
1 2D0 FFFFFFFF 0 1
2 2D0 0 12345678 1
3 20 0 0 0
1 2D0 0BADF00D 0 0
2 2D0 0 0BADF00D 0
1 2F0 1 0 1
1 2D4 55AA55AA 0 1
2 2D4 0 0 1
1 2F0 0 0 0
1 2D4 55AA55AA 0 0
2 2D4 0 55AA55AA 0
3 01 0 0 0
1 2E0 1 0 4
3 10 0 0 6
2 2E4 0 11 6
1 2E8 1 0 6
0 0 0 0 2
2 2E4 0 10 2
1 2DC 0 0 2
3 02 0 0 2
1 2E0 1F 0 2
2 2E0 0 1F 2
1 2DC 1 0 6
1 2E8 1F 0 6
0 0 0 0 0
2 2E4 0 0 0
1 2EC 1 0 8
0 0 0 0 0
1 2EC 2 0 0
0 0 0 0 0
1 2F8 FFFFFFFF 0 0
2 2F8 0 0 0

// ==== chn_regs_top.sv ====
`timescale 1ns/100ps

module chn_regs_top (
  input  logic                                hclk,
  input  logic                                hrst_n,
  input  logic                                hsel,
  input  logic [1:0]                          htrans,
  input  logic [chn_reg_pkg::addr_w-1:0]      haddr,
  input  logic                                hwrite,
  input  logic [chn_reg_pkg::data_w-1:0]      hwdata,
  output logic [chn_reg_pkg::data_w-1:0]      hrdata,
  input  logic                                err_vld,
  input  logic                                tfr_vld,
  input  logic                                htfr_vld,
  input  logic                                trgcmp_vld,
  input  logic                                pend_vld,
  input  logic                                en_clr,
  output logic [chn_reg_pkg::data_w-1:0]      sar,
  output logic [chn_reg_pkg::data_w-1:0]      dar,
  output logic                                dgrpaddrc,
  output logic                                sgrpaddrc,
  output logic                                grpmc,
  output logic [2:0]                          chintmdc,
  output logic [chn_reg_pkg::block_tl_w-1:0]  block_tl,
  output logic [chn_reg_pkg::group_len_w-1:0] group_len,
  output logic [1:0]                          sinc,
  output logic [1:0]                          dinc,
  output logic [1:0]                          src_tr_width,
  output logic [1:0]                          dst_tr_width,
  output logic [chn_reg_pkg::prot_w-1:0]      protctl,
  output logic                                endlan,
  output logic                                srcdtlgc,
  output logic [1:0]                          trgtmdc,
  output logic                                int_en,
  output logic                                chn_en,
  output logic                                soft_trig,
  output logic                                chn_irq,
  output logic                                pend_out
);

  import chn_reg_pkg::*;

  reg_sel_t          wr_sel;
  reg_sel_t          rd_sel;
  logic [data_w-1:0] cfg_rdata;
  logic [data_w-1:0] int_rdata;

  chn_ahb_slave chn_ahb_slave_inst (
    .hclk      (hclk),
    .hrst_n    (hrst_n),
    .hsel      (hsel),
    .htrans    (htrans),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .cfg_rdata (cfg_rdata),
    .int_rdata (int_rdata),
    .wr_sel    (wr_sel),
    .rd_sel    (rd_sel),
    .hrdata    (hrdata)
  );

  chn_cfg_regs chn_cfg_regs_inst (
    .hclk         (hclk),
    .hrst_n       (hrst_n),
    .wr_sel       (wr_sel),
    .rd_sel       (rd_sel),
    .hwdata       (hwdata),
    .en_clr       (en_clr),
    .sar          (sar),
    .dar          (dar),
    .dgrpaddrc    (dgrpaddrc),
    .sgrpaddrc    (sgrpaddrc),
    .grpmc        (grpmc),
    .chintmdc     (chintmdc),
    .block_tl     (block_tl),
    .group_len    (group_len),
    .sinc         (sinc),
    .dinc         (dinc),
    .src_tr_width (src_tr_width),
    .dst_tr_width (dst_tr_width),
    .protctl      (protctl),
    .endlan       (endlan),
    .srcdtlgc     (srcdtlgc),
    .trgtmdc      (trgtmdc),
    .int_en       (int_en),
    .chn_en       (chn_en),
    .soft_trig    (soft_trig),
    .cfg_rdata    (cfg_rdata)
  );

  chn_int_ctrl chn_int_ctrl_inst (
    .hclk       (hclk),
    .hrst_n     (hrst_n),
    .wr_sel     (wr_sel),
    .rd_sel     (rd_sel),
    .hwdata     (hwdata),
    .int_en     (int_en),
    .err_vld    (err_vld),
    .tfr_vld    (tfr_vld),
    .htfr_vld   (htfr_vld),
    .trgcmp_vld (trgcmp_vld),
    .pend_vld   (pend_vld),
    .chn_irq    (chn_irq),
    .pend_out   (pend_out),
    .int_rdata  (int_rdata)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the DMA channel register testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing -f chn_regs.f --top-module tb_chn_regs \
  -Mdir obj_dir -o tb_chn_regs_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_chn_regs_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Test failed" "$log_file"; then
  echo "Simulation reported a failure, see $log_file"
  exit 1
fi

exit 0

// ==== tb_chn_regs.sv ====
`timescale 1ns/100ps

module tb_chn_regs;

  import chn_reg_pkg::*;

  localparam int max_lines = 128;
  localparam int op_write  = 1;
  localparam int op_read   = 2;
  localparam int op_event  = 3;

  logic                   hclk = 1'b0;
  logic                   hrst_n;
  logic                   hsel;
  logic [1:0]             htrans;
  logic [addr_w-1:0]      haddr;
  logic                   hwrite;
  logic [data_w-1:0]      hwdata;
  logic [data_w-1:0]      hrdata;
  logic                   err_vld;
  logic                   tfr_vld;
  logic                   htfr_vld;
  logic                   trgcmp_vld;
  logic                   pend_vld;
  logic                   en_clr;
  logic                   soft_trig;
  logic                   chn_irq;
  logic                   pend_out;
  logic                   chn_en;
  logic [data_w-1:0]      sar;
  logic [data_w-1:0]      dar;
  logic                   dgrpaddrc;
  logic                   sgrpaddrc;
  logic                   grpmc;
  logic [2:0]             chintmdc;
  logic [block_tl_w-1:0]  block_tl;
  logic [group_len_w-1:0] group_len;
  logic [1:0]             sinc;
  logic [1:0]             dinc;
  logic [1:0]             src_tr_width;
  logic [1:0]             dst_tr_width;
  logic [prot_w-1:0]      protctl;
  logic                   endlan;
  logic                   srcdtlgc;
  logic [1:0]             trgtmdc;
  logic                   int_en;
  logic                   exp_valid;
  logic                   exp_read;
  logic [addr_w-1:0]      exp_addr;
  logic [data_w-1:0]      exp_rdata;
  logic [3:0]             exp_flags;
  int                     err_cnt;
  int                     chk_cnt;
  logic [31:0]            pat_op    [max_lines];
  logic [31:0]            pat_addr  [max_lines];
  logic [31:0]            pat_data  [max_lines];
  logic [31:0]            pat_rdata [max_lines];
  logic [31:0]            pat_flags [max_lines];
  int                     line_n = 0;
  int                     cycle_cnt = 0;
  int                     cycle_limit = 100;
  logic                   load_ok;

  always #20 hclk = ~hclk;

  chn_regs_top chn_regs_top_inst (
    .hclk (hclk), .hrst_n (hrst_n), .hsel (hsel), .htrans (htrans), .haddr (haddr),
    .hwrite (hwrite), .hwdata (hwdata), .hrdata (hrdata), .err_vld (err_vld),
    .tfr_vld (tfr_vld), .htfr_vld (htfr_vld), .trgcmp_vld (trgcmp_vld),
    .pend_vld (pend_vld), .en_clr (en_clr), .sar (sar), .dar (dar),
    .dgrpaddrc (dgrpaddrc), .sgrpaddrc (sgrpaddrc), .grpmc (grpmc), .chintmdc (chintmdc),
    .block_tl (block_tl), .group_len (group_len), .sinc (sinc), .dinc (dinc),
    .src_tr_width (src_tr_width), .dst_tr_width (dst_tr_width), .protctl (protctl),
    .endlan (endlan), .srcdtlgc (srcdtlgc), .trgtmdc (trgtmdc), .int_en (int_en),
    .chn_en (chn_en), .soft_trig (soft_trig), .chn_irq (chn_irq), .pend_out (pend_out)
  );

  chn_regs_checker chn_regs_checker_inst (
    .hclk (hclk), .hrst_n (hrst_n), .exp_valid (exp_valid), .exp_read (exp_read),
    .exp_addr (exp_addr), .exp_rdata (exp_rdata), .exp_flags (exp_flags), .hrdata (hrdata),
    .soft_trig (soft_trig), .chn_irq (chn_irq), .pend_out (pend_out), .chn_en (chn_en),
    .sar (sar), .dar (dar), .dgrpaddrc (dgrpaddrc), .sgrpaddrc (sgrpaddrc), .grpmc (grpmc),
    .chintmdc (chintmdc), .block_tl (block_tl), .group_len (group_len), .sinc (sinc),
    .dinc (dinc), .src_tr_width (src_tr_width), .dst_tr_width (dst_tr_width),
    .protctl (protctl), .endlan (endlan), .srcdtlgc (srcdtlgc), .trgtmdc (trgtmdc),
    .int_en (int_en), .err_cnt (err_cnt), .chk_cnt (chk_cnt)
  );

  task automatic load_patterns(output logic ok);
    int          fd;
    int          cnt;
    string       text_line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_data;
    logic [31:0] f_rdata;
    logic [31:0] f_flags;
    ok = 1'b1;
    fd = $fopen("chn_regs_patterns.txt", "r");
    if (fd == 0) begin
      ok = 1'b0;
      $display("ERROR: cannot open pattern file chn_regs_patterns.txt");
    end else begin
      while ($fgets(text_line, fd) != 0) begin
        if (text_line.len() > 1 && text_line.getc(0) != "#") begin
          cnt = $sscanf(text_line, "%h %h %h %h %h", f_op, f_addr, f_data, f_rdata, f_flags);
          if (cnt != 5 || line_n >= max_lines) begin
            ok = 1'b0;
            $display("ERROR: pattern line unreadable or past the table end: %s", text_line);
          end else begin
            pat_op[line_n]    = f_op;
            pat_addr[line_n]  = f_addr;
            pat_data[line_n]  = f_data;
            pat_rdata[line_n] = f_rdata;
            pat_flags[line_n] = f_flags;
            line_n++;
          end
        end
      end
      $fclose(fd);
      if (line_n == 0) begin
        ok = 1'b0;
        $display("ERROR: pattern file holds no operations");
      end
    end
  endtask

  // Address phase of one line, or an idle bus.
  task automatic drive_addr(input int idx);
    if (idx < line_n && (pat_op[idx] == op_write || pat_op[idx] == op_read)) begin
      hsel   = 1'b1;
      htrans = htrans_nonseq;
      haddr  = pat_addr[idx][addr_w-1:0];
      hwrite = (pat_op[idx] == op_write);
    end else begin
      hsel   = 1'b0;
      htrans = 2'b00;
      haddr  = '0;
      hwrite = 1'b0;
    end
  endtask

  // Write data, event strobes and expectations share the data phase.
  task automatic drive_data(input int idx);
    logic [31:0] evt;
    evt        = (pat_op[idx] == op_event) ? pat_addr[idx] : '0;
    hwdata     = (pat_op[idx] == op_write) ? pat_data[idx] : '0;
    err_vld    = evt[0];
    tfr_vld    = evt[1];
    htfr_vld   = evt[2];
    trgcmp_vld = evt[3];
    pend_vld   = evt[4];
    en_clr     = evt[5];
    exp_valid  = 1'b1;
    exp_read   = (pat_op[idx] == op_read);
    exp_addr   = pat_addr[idx][addr_w-1:0];
    exp_rdata  = pat_rdata[idx];
    exp_flags  = pat_flags[idx][3:0];
  endtask

  task automatic clear_data_phase();
    hwdata     = '0;
    err_vld    = 1'b0;
    tfr_vld    = 1'b0;
    htfr_vld   = 1'b0;
    trgcmp_vld = 1'b0;
    pend_vld   = 1'b0;
    en_clr     = 1'b0;
    exp_valid  = 1'b0;
    exp_read   = 1'b0;
    exp_addr   = '0;
    exp_rdata  = '0;
    exp_flags  = '0;
  endtask

  always @(posedge hclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("ERROR: timeout, the run went past %0d clock cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    hrst_n = 1'b0;
    drive_addr(0);
    clear_data_phase();
    load_patterns(load_ok);
    if (!load_ok) begin
      $display("Test failed");
      $finish;
    end else begin
      cycle_limit = 4 * line_n + 100;
      repeat (10) @(negedge hclk);
      hrst_n = 1'b1;
      @(negedge hclk);
      drive_addr(0);
      for (int i = 0; i < line_n; i++) begin
        @(negedge hclk);
        drive_data(i);
        drive_addr(i + 1);  // Next address overlaps this data phase.
      end
      @(negedge hclk);
      clear_data_phase();
      repeat (2) @(negedge hclk);
      $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Test completed successfully");
      end else begin
        $display("Test failed");
      end
      $finish;
    end
  end

endmodule
